// ==== qbert_io.f ====
verilog/qbert_pkg.sv
verilog/ioctl_if.sv
verilog/clock_enables.sv
verilog/spinner.sv
verilog/cabinet_inputs.sv
verilog/rom_loader.sv
verilog/qbert_io_top.sv
tests/tb_qbert_io.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_qbert_io -f qbert_io.f

result=$(./obj_dir/Vtb_qbert_io)
echo "$result"

if echo "$result" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// ==== tests/tb_qbert_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_qbert_io;

	import qbert_pkg::*;

	localparam int          sound_div  = 45;
	localparam logic [24:0] bg_base    = 25'h0010000;
	localparam int          max_cycles = 2000; // about five times the length of all tests
	localparam logic [19:0] free_mask  = 20'h0ff00; // fire e-g and spare bits, no layout uses them

	logic        clk_sys;
	logic        rst;
	core_mod_t   core_mod;
	logic [31:0] status;
	logic  [1:0] buttons;
	logic [19:0] joystick_0;
	logic [19:0] joystick_1;
	logic  [8:0] controls;
	logic        vblank;
	logic        spinner_reset;
	logic        ioctl_download;
	logic  [7:0] ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic  [7:0] ioctl_dout;

	logic        cpu_clk, cen_5, cen_10_p, cen_10_n, sound_cen;
	logic  [7:0] ip1710, ip4740, ipa1j2, dip_sw;
	logic  [1:0] orientation, scanlines;
	logic        pause, flip, rotate, blend, joyswap;
	logic        rom_init, nvram_init, port1_req, port2_req;
	logic [22:0] port1_a;
	logic  [1:0] port1_ds;
	logic [14:0] port2_a;
	logic  [1:0] port2_ds;
	logic        rom_loaded, core_reset, led;

	int          cycles;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          test_errors;
	string       test_name;
	logic [31:0] lfsr_state;

	// mapping vectors, expected words worked out from the cabinet layouts
	core_mod_t   map_mod   [0:15];
	logic [19:0] map_j0    [0:15];
	logic [19:0] map_j1    [0:15];
	logic  [8:0] map_ctl   [0:15];
	logic [31:0] map_st    [0:15];
	logic  [7:0] map_e1710 [0:15];
	logic  [7:0] map_e4740 [0:15];
	int          n_map;

	qbert_io_top #(
		.sound_div (sound_div),
		.bg_base   (bg_base)
	) u_qbert_io_top (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.core_mod       (core_mod),
		.status         (status),
		.buttons        (buttons),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.controls       (controls),
		.vblank         (vblank),
		.spinner_reset  (spinner_reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cpu_clk        (cpu_clk),
		.cen_5          (cen_5),
		.cen_10_p       (cen_10_p),
		.cen_10_n       (cen_10_n),
		.sound_cen      (sound_cen),
		.ip1710         (ip1710),
		.ip4740         (ip4740),
		.ipa1j2         (ipa1j2),
		.dip_sw         (dip_sw),
		.orientation    (orientation),
		.pause          (pause),
		.flip           (flip),
		.rotate         (rotate),
		.blend          (blend),
		.joyswap        (joyswap),
		.scanlines      (scanlines),
		.rom_init       (rom_init),
		.nvram_init     (nvram_init),
		.port1_req      (port1_req),
		.port2_req      (port2_req),
		.port1_a        (port1_a),
		.port1_ds       (port1_ds),
		.port2_a        (port2_a),
		.port2_ds       (port2_ds),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset),
		.led            (led)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("error in %s: %s", test_name, msg);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic add_map_vector(input core_mod_t m, input logic [19:0] j0,
		input logic [19:0] j1, input logic [8:0] ctl, input logic [31:0] st,
		input logic [7:0] e1710, input logic [7:0] e4740);
		map_mod[n_map]   = m;
		map_j0[n_map]    = j0;
		map_j1[n_map]    = j1;
		map_ctl[n_map]   = ctl;
		map_st[n_map]    = st;
		map_e1710[n_map] = e1710;
		map_e4740[n_map] = e4740;
		n_map++;
	endtask

	task automatic measure_enables();
		int   c;
		int   last5, lastp, lastn, lastsnd, lastcpu;
		int   n5, np, nn, nsnd, ncpu;
		logic prev_cpu;
		start_test("reset_and_enables");
		for (c = 0; c < 4; c++) begin
			@(posedge clk_sys);
			if (c == 3) rst <= 1'b0;
			@(negedge clk_sys);
			check_eq("enables in reset", 0, {cpu_clk, cen_5, cen_10_p, cen_10_n, sound_cen});
		end
		check_eq("rom_loaded after reset", 0, rom_loaded);
		check_eq("core_reset after reset", 1, core_reset);
		check_eq("requests after reset", 0, {port1_req, port2_req});
		last5 = -1;
		lastp = -1;
		lastn = -1;
		lastsnd = -1;
		lastcpu = -1;
		n5 = 0;
		np = 0;
		nn = 0;
		nsnd = 0;
		ncpu = 0;
		prev_cpu = 1'b0;
		for (c = 0; c < 200; c++) begin
			@(negedge clk_sys);
			if (c == 0) check_eq("enables after reset", 0,
				{cpu_clk, cen_5, cen_10_p, cen_10_n, sound_cen});
			if (cen_5) begin
				if (last5 >= 0) check_eq("cen_5 spacing", 8, c - last5);
				last5 = c;
				n5++;
			end
			if (cen_10_p) begin
				if (lastp >= 0) check_eq("cen_10_p spacing", 4, c - lastp);
				lastp = c;
				np++;
			end
			if (cen_10_n) begin
				if (lastn >= 0) check_eq("cen_10_n spacing", 4, c - lastn);
				if (lastp >= 0) check_eq("cen_10_n offset", 2, c - lastp);
				lastn = c;
				nn++;
			end
			if (sound_cen) begin
				if (lastsnd >= 0) check_eq("sound_cen spacing", sound_div, c - lastsnd);
				lastsnd = c;
				nsnd++;
			end
			if (cpu_clk != prev_cpu) begin
				if (lastcpu >= 0) check_eq("cpu_clk half period", 4, c - lastcpu);
				lastcpu = c;
				ncpu++;
			end
			prev_cpu = cpu_clk;
		end
		if (n5 < 24) report_error("cen_5 pulsed too rarely");
		if (np < 49) report_error("cen_10_p pulsed too rarely");
		if (nn < 49) report_error("cen_10_n pulsed too rarely");
		if (nsnd < 4) report_error("sound_cen pulsed too rarely");
		if (ncpu < 49) report_error("cpu_clk toggled too rarely");
		end_test();
	endtask

	task automatic pulse_vblank(input logic right, input logic left, inout logic [7:0] exp);
		logic [19:0] jv;
		jv = '0;
		jv[joy_fire_d] = right;
		jv[joy_fire_c] = left;
		@(posedge clk_sys);
		joystick_0 <= jv;
		vblank     <= 1'b1;
		@(posedge clk_sys);
		vblank <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		if (right && !left) exp = exp + 8'd1;
		else if (left && !right) exp = exp - 8'd1;
		check_eq("angle", exp, ipa1j2);
	endtask

	task automatic apply_mapping_table();
		int          i;
		logic [31:0] fill0, fill1;
		logic        vert;
		logic  [7:0] spin_exp;
		logic  [7:0] exp_a1j2;
		start_test("input_mapping");
		spin_exp = 8'd0;
		@(posedge clk_sys);
		core_mod <= mod_mplanets;
		for (i = 0; i < 3; i++) pulse_vblank(1'b1, 1'b0, spin_exp); // dial away from zero
		for (i = 0; i < n_map; i++) begin
			random_bits(20, fill0);
			random_bits(20, fill1);
			@(posedge clk_sys);
			core_mod   <= map_mod[i];
			joystick_0 <= map_j0[i] | (fill0[19:0] & free_mask);
			joystick_1 <= map_j1[i] | (fill1[19:0] & free_mask);
			controls   <= map_ctl[i];
			status     <= map_st[i];
			@(negedge clk_sys);
			vert = map_mod[i] != mod_tylz && map_mod[i] != mod_insector;
			exp_a1j2 = (map_mod[i] == mod_mplanets) ? spin_exp : 8'd0;
			check_eq($sformatf("vector %0d ip1710", i), map_e1710[i], ip1710);
			check_eq($sformatf("vector %0d ip4740", i), map_e4740[i], ip4740);
			check_eq($sformatf("vector %0d ipa1j2", i), exp_a1j2, ipa1j2);
			check_eq($sformatf("vector %0d orientation", i), vert, orientation[0]);
		end
		@(posedge clk_sys);
		spinner_reset <= 1'b1;
		@(posedge clk_sys);
		spinner_reset <= 1'b0;
		end_test();
	endtask

	task automatic sweep_status();
		int          m;
		logic [31:0] st;
		core_mod_t   mv;
		start_test("status_decode");
		for (m = 0; m < 7; m++) begin
			random_bits(32, st);
			mv = core_mod_t'(7'(m));
			@(posedge clk_sys);
			core_mod <= mv;
			status   <= st;
			@(negedge clk_sys);
			check_eq("dip_sw", st[23:16], dip_sw);
			check_eq("flip", st[7], flip);
			check_eq("scanlines", st[4:3], scanlines);
			check_eq("pause", st[1], pause);
			check_eq("rotate", st[2], rotate);
			check_eq("blend", st[5], blend);
			check_eq("joyswap", st[6], joyswap);
			check_eq("orientation", {st[7], mv != mod_tylz && mv != mod_insector}, orientation);
		end
		end_test();
	endtask

	task automatic turn_spinner();
		int         i;
		logic [7:0] exp_angle;
		start_test("spinner");
		@(posedge clk_sys);
		core_mod   <= mod_mplanets; // angle shows on ipa1j2
		status     <= '0;
		joystick_0 <= '0;
		joystick_1 <= '0;
		exp_angle  = 8'd0;
		for (i = 0; i < 5; i++) pulse_vblank(1'b1, 1'b0, exp_angle);
		check_eq("angle after right", 5, ipa1j2);
		for (i = 0; i < 3; i++) pulse_vblank(1'b0, 1'b1, exp_angle);
		check_eq("angle after left", 2, ipa1j2);
		for (i = 0; i < 2; i++) pulse_vblank(1'b1, 1'b1, exp_angle);
		@(posedge clk_sys);
		spinner_reset <= 1'b1;
		@(posedge clk_sys);
		spinner_reset <= 1'b0;
		@(negedge clk_sys);
		check_eq("angle after spinner_reset", 0, ipa1j2);
		end_test();
	endtask

	task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
		repeat (3) @(posedge clk_sys); // one write every 4 cycles
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic download_rom();
		int          i, k, n;
		int          toggles;
		logic [31:0] r;
		logic [24:0] addr, d;
		logic  [7:0] idx;
		start_test("download");
		toggles = 0;
		@(posedge clk_sys);
		ioctl_index    <= rom_index_game;
		ioctl_download <= 1'b1;
		@(negedge clk_sys);
		check_eq("led during download", 0, led);
		check_eq("rom_init", 1, rom_init);
		for (i = 0; i < 5; i++) begin
			random_bits(16, r);
			addr = bg_base + {9'd0, r[15:0]};
			d    = addr - bg_base;
			write_byte(addr, r[7:0]);
			toggles++;
			check_eq("port1_req", toggles % 2, port1_req);
			check_eq("port2_req", toggles % 2, port2_req);
			check_eq("port1_a", addr[23:1], port1_a);
			check_eq("port1_ds", addr[0] ? 2'b10 : 2'b01, port1_ds);
			check_eq("port2_a", {d[13:0], d[15]}, port2_a);
			check_eq("port2_ds", d[14] ? 2'b10 : 2'b01, port2_ds);
		end
		check_eq("core_reset during download", 1, core_reset);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		n = 0;
		while (!rom_loaded && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (!rom_loaded) report_error("rom_loaded did not set after the download ended");
		check_eq("led after download", 1, led);
		for (k = 0; k < 2; k++) begin
			idx = (k == 0) ? rom_index_nvram : 8'h01; // writes that must not reach sdram
			@(posedge clk_sys);
			ioctl_index    <= idx;
			ioctl_download <= 1'b1;
			@(negedge clk_sys);
			check_eq("nvram_init", idx == rom_index_nvram, nvram_init);
			check_eq("rom_init other index", 0, rom_init);
			for (i = 0; i < 3; i++) begin
				write_byte(bg_base + 25'(i), 8'h5a);
				check_eq("port1_req other index", toggles % 2, port1_req);
				check_eq("port2_req other index", toggles % 2, port2_req);
			end
			@(posedge clk_sys);
			ioctl_download <= 1'b0;
		end
		end_test();
	endtask

	task automatic exercise_core_reset();
		int n;
		start_test("core_reset");
		n = 0;
		while (core_reset && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset) report_error("core_reset stayed high after the rom was loaded");
		@(posedge clk_sys);
		status <= 32'h1; // menu reset
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("core_reset from status", 1, core_reset);
		@(posedge clk_sys);
		status <= '0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("core_reset released", 0, core_reset);
		@(posedge clk_sys);
		buttons <= 2'b10;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("core_reset from button", 1, core_reset);
		@(posedge clk_sys);
		buttons <= 2'b00;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_eq("core_reset released again", 0, core_reset);
		end_test();
	endtask

	initial begin
		clk_sys        = 1'b0;
		rst            = 1'b1;
		core_mod       = mod_qbert;
		status         = '0;
		buttons        = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		controls       = '0;
		vblank         = 1'b0;
		spinner_reset  = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cycles         = 0;
		errors         = 0;
		checks         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		lfsr_state     = 32'h0b34991d;
		n_map          = 0;

		//             variant       joy 0     joy 1     ctl     status  1710   4740
		add_map_vector(mod_qbert, 20'h00011, 20'h00008, 9'h011, 32'h000, 8'hc5, 8'h41);
		add_map_vector(mod_qbert, 20'h00009, 20'h00006, 9'h022, 32'h300, 8'h0a, 8'h84);
		add_map_vector(mod_qub, 20'h00006, 20'h00001, 9'h000, 32'h000, 8'h40, 8'h1a);
		add_map_vector(mod_qub, 20'h00005, 20'h0000a, 9'h000, 32'h200, 8'h40, 8'h21);
		add_map_vector(mod_mplanets, 20'h00038, 20'h00000, 9'h021, 32'h000, 8'hc2, 8'hb1);
		add_map_vector(mod_mplanets, 20'h00003, 20'h00000, 9'h012, 32'h300, 8'h01, 8'h4a);
		add_map_vector(mod_krull, 20'h5000a, 20'h00002, 9'h013, 32'h000, 8'hc5, 8'h9e);
		add_map_vector(mod_krull, 20'h00005, 20'h0000c, 9'h020, 32'h200, 8'h09, 8'h65);
		add_map_vector(mod_curvebal, 20'h00054, 20'h00000, 9'h010, 32'h100, 8'h06, 8'h52);
		add_map_vector(mod_curvebal, 20'h000a9, 20'h00000, 9'h020, 32'h200, 8'h09, 8'h56);
		add_map_vector(mod_tylz, 20'h00019, 20'h00000, 9'h021, 32'h000, 8'h07, 8'h36);
		add_map_vector(mod_tylz, 20'h0000a, 20'h00000, 9'h002, 32'h200, 8'h01, 8'h48);
		add_map_vector(mod_insector, 20'h00021, 20'h0001a, 9'h030, 32'h000, 8'h5e, 8'h92);
		add_map_vector(mod_insector, 20'h0001e, 20'h00025, 9'h001, 32'h300, 8'h21, 8'h6d);
		add_map_vector(core_mod_t'(7'd9), 20'h0001f, 20'h00000, 9'h000, 32'h000, 8'hc0, 8'h0f);

		measure_enables();
		apply_mapping_table();
		sweep_status();
		turn_spinner();
		download_rom();
		exercise_core_reset();

		$display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cabinet_inputs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cabinet_inputs (
	input  qbert_pkg::core_mod_t core_mod,
	input  wire  [31:0] status,
	input  wire  [19:0] joystick_0,
	input  wire  [19:0] joystick_1,
	input  wire   [8:0] controls,
	input  wire   [7:0] spin_angle,
	output logic  [7:0] ip1710,
	output logic  [7:0] ip4740,
	output logic  [7:0] ipa1j2,
	output logic  [7:0] dip_sw,
	output logic  [1:0] orientation,
	output logic        pause,
	output logic        flip,
	output logic        rotate,
	output logic        blend,
	output logic        joyswap,
	output logic  [1:0] scanlines
);

	import qbert_pkg::*;

	logic service;
	logic diagonal;

	logic right, left, down, up;
	logic fire_a, fire_b, fire_c, fire_d;
	logic right_b, left_b, down_b, up_b;
	logic right2, left2, down2, up2;
	logic fire2_a, fire2_b;
	logic p1, p2, coin1, coin2;

	assign pause     = status[st_pause];
	assign rotate    = status[st_rotate];
	assign scanlines = status[st_scan_lo +: 2];
	assign blend     = status[st_blend];
	assign joyswap   = status[st_joyswap];
	assign flip      = status[st_flip];
	assign service   = status[st_service];
	assign diagonal  = status[st_diagonal];
	assign dip_sw    = status[st_dip_lo +: 8];

	// vertical monitor except on the two horizontal games
	assign orientation = {flip, core_mod != mod_tylz && core_mod != mod_insector};

	assign right   = joystick_0[joy_right];
	assign left    = joystick_0[joy_left];
	assign down    = joystick_0[joy_down];
	assign up      = joystick_0[joy_up];
	assign fire_a  = joystick_0[joy_fire_a];
	assign fire_b  = joystick_0[joy_fire_b];
	assign fire_c  = joystick_0[joy_fire_c];
	assign fire_d  = joystick_0[joy_fire_d];
	assign right_b = joystick_0[joy_right_b];
	assign left_b  = joystick_0[joy_left_b];
	assign down_b  = joystick_0[joy_down_b];
	assign up_b    = joystick_0[joy_up_b];

	assign right2  = joystick_1[joy_right];
	assign left2   = joystick_1[joy_left];
	assign down2   = joystick_1[joy_down];
	assign up2     = joystick_1[joy_up];
	assign fire2_a = joystick_1[joy_fire_a];
	assign fire2_b = joystick_1[joy_fire_b];

	assign p1    = controls[ctl_p1];
	assign p2    = controls[ctl_p2];
	assign coin1 = controls[ctl_coin1];
	assign coin2 = controls[ctl_coin2];

	// port layouts per variant, MSB first
	always_comb begin
		ipa1j2 = 8'd0;
		ip1710 = {fire_a, ~service, 2'b00, coin2, coin1, p2, p1};
		if (diagonal) begin
			ip4740 = {down2 & left2, up2 & right2, left2 & up2, right2 & down2,
				down & left, up & right, left & up, right & down}; // 45 degree stick
		end else begin
			ip4740 = {down2, up2, left2, right2, down, up, left, right};
		end

		case (core_mod)
			mod_mplanets: begin
				ip1710 = {~service, fire_a, 4'd0, coin2, coin1};
				ip4740 = {fire_b, p2, p1, fire_a, left, down, right, up};
				ipa1j2 = spin_angle;
			end
			mod_krull: begin
				ip1710 = {p2, p1, 2'b00, coin2, coin1, fire_a, ~service};
				ip4740 = {left, down, right, up,
					left2 | left_b, down2 | down_b, right2 | right_b, up2 | up_b}; // twin stick
			end
			mod_curvebal: begin
				ip1710 = {4'd0, coin2, coin1, fire_a, ~service};
				ip4740 = {1'b0, fire_d | down, 1'b0, fire_c | right,
					1'b0, fire_b | left, fire_a | up, 1'b0}; // bunt, pitches, swing
			end
			mod_tylz: begin
				ip1710 = {4'd0, coin1, coin2, fire_a, ~service};
				ip4740 = {1'b0, p2, p1, fire_a,
					diagonal ? left & up    : left,
					diagonal ? right & up   : up,
					diagonal ? right & down : right,
					diagonal ? left & down  : down};
			end
			mod_insector: begin
				ip1710 = {1'b0, ~service, fire2_b, fire2_a, coin2, coin1, fire_b, fire_a};
				ip4740 = {left2, down2, right2, up2, left, down, right, up};
			end
			default: begin
				// q*bert layout, also qubes and unknown codes
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/clock_enables.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_enables #(
	parameter int sound_div = 45
) (
	input  wire  clk_sys,
	input  wire  rst,
	output logic cpu_clk,
	output logic cen_5,
	output logic cen_10_p,
	output logic cen_10_n,
	output logic sound_cen
);

	localparam int snd_w = (sound_div > 1) ? $clog2(sound_div) : 1;

	logic [2:0]       phase;
	logic [snd_w-1:0] snd_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase    <= 3'd0;
			cpu_clk  <= 1'b0;
			cen_5    <= 1'b0;
			cen_10_p <= 1'b0;
			cen_10_n <= 1'b0;
		end else begin
			phase    <= phase + 3'd1; // wraps at 8
			cpu_clk  <= phase[2];
			cen_5    <= phase == 3'd7;
			cen_10_p <= phase == 3'd3 || phase == 3'd7;
			cen_10_n <= phase == 3'd1 || phase == 3'd5; // half a 10 MHz period later
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			snd_cnt   <= '0;
			sound_cen <= 1'b0;
		end else if (snd_cnt == snd_w'(sound_div - 1)) begin
			snd_cnt   <= '0;
			sound_cen <= 1'b1;
		end else begin
			snd_cnt   <= snd_cnt + 1'b1;
			sound_cen <= 1'b0;
		end
	end

	// both phases of the 10 MHz enable must stay disjoint
	a_cen_10_disjoint: assert property (@(posedge clk_sys) disable iff (rst)
		!(cen_10_p && cen_10_n));

endmodule

`default_nettype wire

// ==== verilog/ioctl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ioctl_if;

	logic        download;
	logic  [7:0] index;
	logic        wr;
	logic [24:0] addr;
	logic  [7:0] dout;

	modport source (
		output download, index, wr, addr, dout
	);

	modport loader (
		input download, index, wr, addr, dout
	);

endinterface

`default_nettype wire

// ==== verilog/qbert_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module qbert_io_top #(
	parameter int          sound_div = 45,
	parameter logic [24:0] bg_base   = 25'h0010000
) (
	input  wire                  clk_sys,
	input  wire                  rst,
	input  qbert_pkg::core_mod_t core_mod,
	input  wire           [31:0] status,
	input  wire            [1:0] buttons,
	input  wire           [19:0] joystick_0,
	input  wire           [19:0] joystick_1,
	input  wire            [8:0] controls,
	input  wire                  vblank,
	input  wire                  spinner_reset,
	input  wire                  ioctl_download,
	input  wire            [7:0] ioctl_index,
	input  wire                  ioctl_wr,
	input  wire           [24:0] ioctl_addr,
	input  wire            [7:0] ioctl_dout,
	output logic                 cpu_clk,
	output logic                 cen_5,
	output logic                 cen_10_p,
	output logic                 cen_10_n,
	output logic                 sound_cen,
	output logic           [7:0] ip1710,
	output logic           [7:0] ip4740,
	output logic           [7:0] ipa1j2,
	output logic           [7:0] dip_sw,
	output logic           [1:0] orientation,
	output logic                 pause,
	output logic                 flip,
	output logic                 rotate,
	output logic                 blend,
	output logic                 joyswap,
	output logic           [1:0] scanlines,
	output logic                 rom_init,
	output logic                 nvram_init,
	output logic                 port1_req,
	output logic                 port2_req,
	output logic          [22:0] port1_a,
	output logic           [1:0] port1_ds,
	output logic          [14:0] port2_a,
	output logic           [1:0] port2_ds,
	output logic                 rom_loaded,
	output logic                 core_reset,
	output logic                 led
);

	import qbert_pkg::*;

	logic [7:0] spin_angle;
	logic       spin_left;
	logic       spin_right;

	ioctl_if u_ioctl ();

	assign u_ioctl.download = ioctl_download;
	assign u_ioctl.index    = ioctl_index;
	assign u_ioctl.wr       = ioctl_wr;
	assign u_ioctl.addr     = ioctl_addr;
	assign u_ioctl.dout     = ioctl_dout;

	// fire c/d or the second stick turn the dial
	assign spin_left  = joystick_0[joy_fire_c] | joystick_0[joy_left_b];
	assign spin_right = joystick_0[joy_fire_d] | joystick_0[joy_right_b];

	clock_enables #(
		.sound_div (sound_div)
	) u_clock_enables (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.cpu_clk   (cpu_clk),
		.cen_5     (cen_5),
		.cen_10_p  (cen_10_p),
		.cen_10_n  (cen_10_n),
		.sound_cen (sound_cen)
	);

	spinner u_spinner (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.spinner_reset (spinner_reset),
		.btn_left      (spin_left),
		.btn_right     (spin_right),
		.vblank        (vblank),
		.angle         (spin_angle)
	);

	cabinet_inputs u_cabinet_inputs (
		.core_mod    (core_mod),
		.status      (status),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.controls    (controls),
		.spin_angle  (spin_angle),
		.ip1710      (ip1710),
		.ip4740      (ip4740),
		.ipa1j2      (ipa1j2),
		.dip_sw      (dip_sw),
		.orientation (orientation),
		.pause       (pause),
		.flip        (flip),
		.rotate      (rotate),
		.blend       (blend),
		.joyswap     (joyswap),
		.scanlines   (scanlines)
	);

	rom_loader #(
		.bg_base (bg_base)
	) u_rom_loader (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.ioctl        (u_ioctl.loader),
		.menu_reset   (status[st_reset]),
		.button_reset (buttons[1]),
		.rom_init     (rom_init),
		.nvram_init   (nvram_init),
		.port1_req    (port1_req),
		.port2_req    (port2_req),
		.port1_a      (port1_a),
		.port1_ds     (port1_ds),
		.port2_a      (port2_a),
		.port2_ds     (port2_ds),
		.rom_loaded   (rom_loaded),
		.core_reset   (core_reset),
		.led          (led)
	);

endmodule

`default_nettype wire

// ==== verilog/qbert_pkg.sv ====
`default_nettype none

package qbert_pkg;

	// game variant, as reported by the menu firmware
	typedef enum logic [6:0] {
		mod_qbert    = 7'd0,
		mod_qub      = 7'd1,
		mod_mplanets = 7'd2,
		mod_krull    = 7'd3,
		mod_curvebal = 7'd4,
		mod_tylz     = 7'd5,
		mod_insector = 7'd6
	} core_mod_t;

	// player word, 20 bits
	localparam int joy_right   = 0;
	localparam int joy_left    = 1;
	localparam int joy_down    = 2;
	localparam int joy_up      = 3;
	localparam int joy_fire_a  = 4;
	localparam int joy_fire_b  = 5;
	localparam int joy_fire_c  = 6;
	localparam int joy_fire_d  = 7;
	localparam int joy_fire_e  = 8;
	localparam int joy_fire_f  = 9;
	localparam int joy_fire_g  = 10;
	localparam int joy_right_b = 16; // second stick
	localparam int joy_left_b  = 17;
	localparam int joy_down_b  = 18;
	localparam int joy_up_b    = 19;

	// control word, 9 bits
	localparam int ctl_p1    = 0;
	localparam int ctl_p2    = 1;
	localparam int ctl_coin1 = 4;
	localparam int ctl_coin2 = 5;

	// menu status word
	localparam int st_reset    = 0;
	localparam int st_pause    = 1;
	localparam int st_rotate   = 2;
	localparam int st_scan_lo  = 3; // 2 bits
	localparam int st_blend    = 5;
	localparam int st_joyswap  = 6;
	localparam int st_flip     = 7;
	localparam int st_service  = 8;
	localparam int st_diagonal = 9;
	localparam int st_dip_lo   = 16; // 8 bits

	localparam logic [7:0] rom_index_game  = 8'h00;
	localparam logic [7:0] rom_index_nvram = 8'hff;

endpackage

`default_nettype wire

// ==== verilog/rom_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_loader #(
	parameter logic [24:0] bg_base = 25'h0010000
) (
	input  wire         clk_sys,
	input  wire         rst,
	ioctl_if.loader     ioctl,
	input  wire         menu_reset,
	input  wire         button_reset,
	output logic        rom_init,
	output logic        nvram_init,
	output logic        port1_req,
	output logic        port2_req,
	output logic [22:0] port1_a,
	output logic  [1:0] port1_ds,
	output logic [14:0] port2_a,
	output logic  [1:0] port2_ds,
	output logic        rom_loaded,
	output logic        core_reset,
	output logic        led
);

	import qbert_pkg::*;

	logic        wr_last;
	logic        download_d;
	logic [15:0] bg_addr;

	assign rom_init   = ioctl.download && ioctl.index == rom_index_game;
	assign nvram_init = ioctl.download && ioctl.index == rom_index_nvram;
	assign led        = ~ioctl.download;

	// 16-bit words on port 1
	assign port1_a  = ioctl.addr[23:1];
	assign port1_ds = {ioctl.addr[0], ~ioctl.addr[0]};

	// sprite roms interleaved into 32-bit words
	assign bg_addr  = ioctl.addr[15:0] - bg_base[15:0];
	assign port2_a  = {bg_addr[13:0], bg_addr[15]};
	assign port2_ds = {bg_addr[14], ~bg_addr[14]};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_last   <= 1'b0;
			port1_req <= 1'b0;
			port2_req <= 1'b0;
		end else begin
			wr_last <= ioctl.wr;
			if (rom_init && ioctl.wr && !wr_last) begin
				port1_req <= ~port1_req;
				port2_req <= ~port2_req;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl.download;
			if (download_d && !ioctl.download) rom_loaded <= 1'b1; // end of download
			core_reset <= menu_reset | button_reset | ~rom_loaded;
		end
	end

	a_req_pair: assert property (@(posedge clk_sys) disable iff (rst)
		port1_req == port2_req);

endmodule

`default_nettype wire

// ==== verilog/spinner.sv ====
`timescale 1ns/1ps
`default_nettype none

module spinner (
	input  wire        clk_sys,
	input  wire        rst,
	input  wire        spinner_reset,
	input  wire        btn_left,
	input  wire        btn_right,
	input  wire        vblank,
	output logic [7:0] angle
);

	logic vblank_d;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vblank_d <= 1'b0;
		end else begin
			vblank_d <= vblank;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst || spinner_reset) begin
			angle <= 8'd0;
		end else if (vblank && !vblank_d) begin // once per frame
			case ({btn_right, btn_left})
				2'b10: angle <= angle + 8'd1;
				2'b01: angle <= angle - 8'd1;
				default: angle <= angle; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire
